// ==== tests/ex_cases.txt ====
# name pc instr rs1_data rs2_data expected_result
# all values in hex, one instruction per line
add_ovf      00001000 003100B3 7FFFFFFF 00000001 80000000
sub_neg      00001000 403100B3 00000005 00000007 FFFFFFFE
sll_mask     00001000 003110B3 00000001 0000002F 00008000
slt_neg      00001000 003120B3 FFFFFFFF 00000001 00000001
sltu_neg     00001000 003130B3 FFFFFFFF 00000001 00000000
slt_pos      00001000 003120B3 00000001 FFFFFFFF 00000000
sltu_pos     00001000 003130B3 00000001 FFFFFFFF 00000001
xor_mix      00001000 003140B3 F0F0F0F0 0FF00FF0 FF00FF00
srl_neg      00001000 003150B3 80000000 00000004 08000000
sra_neg      00001000 403150B3 80000000 00000004 F8000000
or_join      00001000 003160B3 12340000 00005678 12345678
and_mask     00001000 003170B3 FFFF0000 12345678 12340000
addi_neg     00001000 FFF10093 00000010 DEADBEEF 0000000F
addi_max     00001000 7FF10093 00000001 DEADBEEF 00000800
slti_pos     00001000 FFF12093 00000005 DEADBEEF 00000000
slti_neg     00001000 FFF12093 FFFFFFFE DEADBEEF 00000001
sltiu_big    00001000 FFF13093 00000005 DEADBEEF 00000001
xori_inv     00001000 FFF14093 0000FF00 DEADBEEF FFFF00FF
ori_low      00001000 0F016093 00000F00 DEADBEEF 00000FF0
andi_byte    00001000 0FF17093 12345678 DEADBEEF 00000078
slli_4       00001000 00411093 00000003 DEADBEEF 00000030
srli_8       00001000 00815093 F0000000 DEADBEEF 00F00000
srai_8       00001000 40815093 F0000000 DEADBEEF FFF00000
lb_addr      00001000 FFC10083 00002000 DEADBEEF 00001FFC
lh_addr      00001000 01011083 00002000 DEADBEEF 00002010
lw_addr      00001000 7FF12083 00002000 DEADBEEF 000027FF
lbu_addr     00001000 00114083 00002000 DEADBEEF 00002001
lhu_addr     00001000 FFE15083 00002000 DEADBEEF 00001FFE
sb_addr      00001000 00310423 00003000 000000AA 00003008
sh_addr      00001000 FE311C23 00003000 0000BBBB 00002FF8
sw_addr      00001000 02312223 00003000 CCCCCCCC 00003024
lui_imm      00001000 123450B7 FFFFFFFF FFFFFFFF 12345000
auipc_pos    00001000 00001097 FFFFFFFF FFFFFFFF 00002000
auipc_neg    00004000 FFFFF097 FFFFFFFF FFFFFFFF 00003000
jal_link     00001000 008000EF FFFFFFFF FFFFFFFF 00001004
jalr_link    00001FFC 00C100E7 00000040 FFFFFFFF 00002000
mul_bad_f7   00001000 023100B3 00000006 00000007 00000000
xor_bad_f7   00001000 403140B3 00000006 00000007 00000000
slli_bad_f7  00001000 40411093 00000003 DEADBEEF 00000000
ld_bad_f3    00001000 00013083 00002000 DEADBEEF 00000000
sd_bad_f3    00001000 00313023 00003000 DEADBEEF 00000000
beq_branch   00001000 00310463 00000005 00000005 00000000
fence_op     00001000 0FF0000F 00000005 00000005 00000000
all_ones     00001000 FFFFFFFF 00000005 00000005 00000000

// ==== src.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/credit_tracker.sv
logic/ex_unit_top.sv
tests/ex_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute unit testbench

TOP = ex_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== tests/ex_unit_tb.sv ====
/* Execute unit testbench */
module ex_unit_tb import isa_pkg::*, pipe_pkg::*; ();

    logic            clk = 1'b0;
    logic            reset;
    logic            in_valid;
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            out_credit;
    logic            in_credit;
    logic            out_valid;
    logic [XLEN-1:0] result;

    string           case_name[$];                // Case table from the file
    logic [XLEN-1:0] case_pc[$];
    logic [XLEN-1:0] case_instr[$];
    logic [XLEN-1:0] case_rs1[$];
    logic [XLEN-1:0] case_rs2[$];
    logic [XLEN-1:0] case_exp[$];

    string           name_q[$];                   // Items in flight in send order
    logic [XLEN-1:0] exp_q[$];
    int              sent_cycle_q[$];

    logic [31:0]     lfsr = 32'h9753;
    int              cycle = 0;
    int              errors = 0;
    int              n_cases = 0;
    int              send_credits = PIPE_DEPTH;   // Sender's slots
    int              tb_credits = OUT_CREDITS;    // Copy of the DUT consumer credits
    int              pending_returns = 0;         // Slots the consumer has yet to free
    int              out_count = 0;
    int              credit_count = 0;
    bit              loaded = 1'b0;
    bit              sent_any = 1'b0;
    bit              fast_pass = 1'b0;            // Latency checked only here

    ex_unit_top ex_unit_top_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .pc         (pc),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .result     (result)
    );

    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    function automatic bit rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %b, actual %b at cycle %0d", name, expected, actual,
                     cycle);
            errors++;
        end
    endtask

    task automatic load_cases();
        int              fd;
        int              n;
        string           line;
        string           tag;
        logic [XLEN-1:0] v_pc, v_instr, v_rs1, v_rs2, v_exp;
        fd = $fopen("tests/ex_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/ex_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;                         // Blank or column notes
            n = $sscanf(line, "%s %h %h %h %h %h", tag, v_pc, v_instr, v_rs1, v_rs2, v_exp);
            if (n == 6) begin
                case_name.push_back(tag);
                case_pc.push_back(v_pc);
                case_instr.push_back(v_instr);
                case_rs1.push_back(v_rs1);
                case_rs2.push_back(v_rs2);
                case_exp.push_back(v_exp);
            end
        end
        $fclose(fd);
        n_cases = case_name.size();
    endtask

    // Sender and consumer step 10 units after the rising edge
    task automatic run_pass(input bit slow);
        int idx;
        bit go;
        idx = 0;
        fast_pass = !slow;
        while (idx < n_cases || exp_q.size() > 0 || pending_returns > 0) begin
            @(posedge clk);
            #10;
            go = 1'b1;
            if (slow)
                go = rand_bit() & rand_bit();     // Frees a slot one time in four
            out_credit = (pending_returns > 0) && go;
            if (out_credit)
                pending_returns--;
            go = 1'b1;
            if (slow)
                go = rand_bit();                  // Idle gap half the time
            in_valid = 1'b0;
            if (idx < n_cases && send_credits > 0 && go) begin
                in_valid = 1'b1;
                pc       = case_pc[idx];
                instr    = case_instr[idx];
                rs1_data = case_rs1[idx];
                rs2_data = case_rs2[idx];
                name_q.push_back(case_name[idx]);
                exp_q.push_back(case_exp[idx]);
                sent_cycle_q.push_back(cycle);
                send_credits--;
                sent_any = 1'b1;
                idx++;
            end
        end
    endtask

    task automatic take_result();
        string name;
        int    sent;
        name = name_q.pop_front();
        sent = sent_cycle_q.pop_front();
        check_result(name, exp_q.pop_front(), result);
        if (fast_pass && cycle - sent != 2) begin
            $display("%s came out %0d cycles after it was sent instead of 2", name,
                     cycle - sent);
            errors++;
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_flag("in_credit with out_valid", out_valid, in_credit);
            if (!sent_any)
                check_flag("out_valid before first item", 1'b0, out_valid);
            if (in_credit) begin
                credit_count++;
                send_credits++;                   // Slot back to the sender
            end
            if (out_valid) begin
                out_count++;
                pending_returns++;
                if (tb_credits <= 0) begin
                    $display("out_valid fired at cycle %0d with no consumer credit", cycle);
                    errors++;
                end
                tb_credits--;
                if (exp_q.size() == 0) begin
                    $display("A result came out at cycle %0d with nothing in flight", cycle);
                    errors++;
                end else
                    take_result();
            end
            if (out_credit)
                tb_credits++;                     // Counts in the DUT from the next edge
        end
    end

    initial begin
        wait (loaded);
        repeat ((n_cases * 2 + 1) * 40) @(posedge clk); // 40 cycles per case over two passes
        $display("Timeout: the run did not end within %0d cycles", (n_cases * 2 + 1) * 40);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        pc         = '0;
        instr      = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        out_credit = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (3) @(posedge clk);                // Idle cycles with outputs low
        run_pass(1'b0);                           // Back to back with credits always free
        run_pass(1'b1);                           // Gaps and slow consumer
        @(posedge clk);
        #10;
        out_credit = 1'b0;
        repeat (4) @(posedge clk);                // Nothing more may come out
        if (n_cases == 0) begin
            $display("No cases were read from tests/ex_cases.txt");
            errors++;
        end
        if (out_count != 2 * n_cases || exp_q.size() != 0) begin
            $display("Got %0d results but sent %0d items", out_count, 2 * n_cases);
            errors++;
        end
        if (credit_count != out_count || send_credits != PIPE_DEPTH) begin
            $display("Sender credits did not all come back");
            errors++;
        end
        $display("Errors: %0d, results: %0d of %0d, in_credit pulses: %0d", errors,
                 out_count, 2 * n_cases, credit_count);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== logic/ex_unit_top.sv ====
/* RV32I execute unit */
module ex_unit_top import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic [XLEN-1:0] pc,
    input  instr_u          instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic            out_credit,
    output logic            in_credit,
    output logic            out_valid,
    output logic [XLEN-1:0] result
);

    logic            dec_valid;
    logic [OP_W-1:0] dec_op;
    logic [XLEN-1:0] dec_a, dec_b;
    logic            ex_ready, ex_valid;
    logic [XLEN-1:0] ex_result;
    logic            issue;

    decode_stage decode_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .pc        (pc),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_ready  (ex_ready),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .issue     (issue),
        .ex_ready  (ex_ready),
        .ex_valid  (ex_valid),
        .ex_result (ex_result)
    );

    credit_tracker credit_tracker_i (
        .clk        (clk),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .out_credit (out_credit),
        .issue      (issue),
        .out_valid  (out_valid),
        .in_credit  (in_credit)
    );

    assign result = ex_result;                    // Held until issued

endmodule

// ==== logic/credit_tracker.sv ====
/* Downstream credit tracker */
module credit_tracker import pipe_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic ex_valid,                        // Result waiting in execute slot
    input  logic out_credit,                      // Consumer freed a slot
    output logic issue,
    output logic out_valid,
    output logic in_credit                        // Slot returned to sender
);

    logic [CREDIT_W-1:0] count;

    assign issue     = ex_valid && (count != '0);
    assign out_valid = issue;                     // Same pulse
    assign in_credit = issue;

    always_ff @(posedge clk) begin
        if (reset)
            count <= CREDIT_W'(OUT_CREDITS);
        else begin
            case ({issue, out_credit})
                2'b10:   count <= count - 1'b1;   // Spend one
                2'b01:   count <= count + 1'b1;   // Returned
                default: count <= count;          // Both or neither
            endcase
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
/* Execute stage */
module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            dec_valid,
    input  logic [OP_W-1:0] dec_op,
    input  logic [XLEN-1:0] dec_a,
    input  logic [XLEN-1:0] dec_b,
    input  logic            issue,                // Held result leaves this cycle
    output logic            ex_ready,
    output logic            ex_valid,
    output logic [XLEN-1:0] ex_result
);

    logic [XLEN-1:0] alu;
    logic [4:0]      sh;                          // Shift amount
    logic            load;

    assign sh = dec_b[4:0];

    always_comb begin
        case (dec_op)
            OP_ADD:  alu = dec_a + dec_b;
            OP_SUB:  alu = dec_a - dec_b;
            OP_SLL:  alu = dec_a << sh;
            OP_SLT:  alu = {{(XLEN-1){1'b0}}, $signed(dec_a) < $signed(dec_b)};
            OP_SLTU: alu = {{(XLEN-1){1'b0}}, dec_a < dec_b};
            OP_XOR:  alu = dec_a ^ dec_b;
            OP_SRL:  alu = dec_a >> sh;
            OP_SRA:  alu = $unsigned($signed(dec_a) >>> sh); // Sign bit fills
            OP_OR:   alu = dec_a | dec_b;
            OP_AND:  alu = dec_a & dec_b;
            OP_ZERO: alu = '0;
            default: alu = '0;                    // Unused codes
        endcase
    end

    // Slot free now or freed by this cycle's issue
    assign ex_ready = !ex_valid || issue;
    assign load     = dec_valid && ex_ready;

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else if (load)
            ex_valid <= 1'b1;                     // New item replaces issued one
        else if (issue)
            ex_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load)
            ex_result <= alu;
    end

endmodule

// ==== logic/decode_stage.sv ====
/* Decode stage */
module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,             // One cycle per item
    input  logic [XLEN-1:0] pc,
    input  instr_u          instr,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic            ex_ready,             // Execute slot free or leaving
    output logic            dec_valid,
    output logic [OP_W-1:0] dec_op,
    output logic [XLEN-1:0] dec_a,
    output logic [XLEN-1:0] dec_b
);

    logic [XLEN-1:0]  imm_i, imm_s, imm_u, shamt;
    logic [XLEN-1:0]  imm;                        // Chosen immediate
    logic [SEL_W-1:0] sel;
    logic [OP_W-1:0]  next_op;
    logic [XLEN-1:0]  next_a, next_b;
    logic             f7_base, f7_alt;
    logic             advance;

    assign imm_i   = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};               // Sign-extended
    assign imm_s   = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_u   = {instr.u.imm_31_12, 12'b0};
    assign shamt   = {27'b0, instr.i.imm_11_0[4:0]};                                // Shift-immediate amount
    assign f7_base = (instr.r.funct7 == F7_BASE);  // Also upper imm bits of SLLI/SRxI
    assign f7_alt  = (instr.r.funct7 == F7_ALT);

    always_comb begin
        next_op = OP_ZERO;                        // Anything unlisted gives zero
        sel     = SEL_ZERO_IMM;
        imm     = '0;
        case (instr.r.opcode)
            OPC_OP: begin
                sel = SEL_RS1_RS2;
                case (instr.r.funct3)
                    F3_ADD_SUB: next_op = f7_base ? OP_ADD : (f7_alt ? OP_SUB : OP_ZERO);
                    F3_SLL:     next_op = f7_base ? OP_SLL  : OP_ZERO;
                    F3_SLT:     next_op = f7_base ? OP_SLT  : OP_ZERO;
                    F3_SLTU:    next_op = f7_base ? OP_SLTU : OP_ZERO;
                    F3_XOR:     next_op = f7_base ? OP_XOR  : OP_ZERO;
                    F3_SR:      next_op = f7_base ? OP_SRL : (f7_alt ? OP_SRA : OP_ZERO);
                    F3_OR:      next_op = f7_base ? OP_OR   : OP_ZERO;
                    default:    next_op = f7_base ? OP_AND  : OP_ZERO; // F3_AND
                endcase
            end
            OPC_OP_IMM: begin
                sel = SEL_RS1_IMM;
                imm = imm_i;
                case (instr.i.funct3)
                    F3_ADD_SUB: next_op = OP_ADD; // ADDI
                    F3_SLT:     next_op = OP_SLT;
                    F3_SLTU:    next_op = OP_SLTU;
                    F3_XOR:     next_op = OP_XOR;
                    F3_OR:      next_op = OP_OR;
                    F3_AND:     next_op = OP_AND;
                    F3_SLL: begin
                        imm     = shamt;
                        next_op = f7_base ? OP_SLL : OP_ZERO;
                    end
                    default: begin                // F3_SR
                        imm     = shamt;
                        next_op = f7_base ? OP_SRL : (f7_alt ? OP_SRA : OP_ZERO);
                    end
                endcase
            end
            OPC_LOAD: begin
                sel = SEL_RS1_IMM;
                imm = imm_i;
                // LB, LH, LW, LBU, LHU
                if (instr.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                    next_op = OP_ADD;
            end
            OPC_STORE: begin
                sel = SEL_RS1_IMM;
                imm = imm_s;
                if (instr.s.funct3 inside {3'b000, 3'b001, 3'b010}) // SB, SH, SW
                    next_op = OP_ADD;
            end
            OPC_LUI: begin
                imm     = imm_u;                  // Zero plus upper immediate
                next_op = OP_ADD;
            end
            OPC_AUIPC: begin
                sel     = SEL_PC_IMM;
                imm     = imm_u;
                next_op = OP_ADD;
            end
            OPC_JAL: begin
                sel     = SEL_PC_IMM;
                imm     = XLEN'(4);               // Link value
                next_op = OP_ADD;
            end
            OPC_JALR: begin
                sel = SEL_PC_IMM;
                imm = XLEN'(4);
                if (instr.i.funct3 == 3'b000)
                    next_op = OP_ADD;
            end
            default: ;                            // Branches and others
        endcase
    end

    always_comb begin
        case (sel)
            SEL_RS1_RS2: begin
                next_a = rs1_data;
                next_b = rs2_data;
            end
            SEL_RS1_IMM: begin
                next_a = rs1_data;
                next_b = imm;
            end
            SEL_PC_IMM: begin
                next_a = pc;
                next_b = imm;
            end
            default: begin                        // SEL_ZERO_IMM
                next_a = '0;
                next_b = imm;
            end
        endcase
    end

    assign advance = ex_ready || !dec_valid;      // Fill when empty, hold when blocked

    always_ff @(posedge clk) begin
        if (reset)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (advance) begin                        // Payload only
            dec_op <= next_op;
            dec_a  <= next_a;
            dec_b  <= next_b;
        end
    end

endmodule

// ==== logic/pipe_pkg.sv ====
/* Execute pipeline definitions */
package pipe_pkg;

    localparam int OP_W = 4;                      // Internal operation code width

    localparam logic [OP_W-1:0] OP_ADD  = 4'd0;
    localparam logic [OP_W-1:0] OP_SUB  = 4'd1;
    localparam logic [OP_W-1:0] OP_SLL  = 4'd2;
    localparam logic [OP_W-1:0] OP_SLT  = 4'd3;   // Signed compare
    localparam logic [OP_W-1:0] OP_SLTU = 4'd4;   // Unsigned compare
    localparam logic [OP_W-1:0] OP_XOR  = 4'd5;
    localparam logic [OP_W-1:0] OP_SRL  = 4'd6;
    localparam logic [OP_W-1:0] OP_SRA  = 4'd7;
    localparam logic [OP_W-1:0] OP_OR   = 4'd8;
    localparam logic [OP_W-1:0] OP_AND  = 4'd9;
    localparam logic [OP_W-1:0] OP_ZERO = 4'd10;  // Unsupported encoding

    localparam int SEL_W = 2;                     // Operand-select code width

    localparam logic [SEL_W-1:0] SEL_RS1_RS2  = 2'd0;
    localparam logic [SEL_W-1:0] SEL_RS1_IMM  = 2'd1;
    localparam logic [SEL_W-1:0] SEL_PC_IMM   = 2'd2;
    localparam logic [SEL_W-1:0] SEL_ZERO_IMM = 2'd3;

    // Flow control
    localparam int PIPE_DEPTH  = 2;               // Slots the sender may fill
    localparam int OUT_CREDITS = 4;               // Initial consumer credits
    localparam int CREDIT_W    = 3;               // Wide enough for OUT_CREDITS

endpackage

// ==== logic/isa_pkg.sv ====
/* RV32I encoding definitions */
package isa_pkg;

    localparam int XLEN = 32;                     // Data path width

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ALU funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000; // ADD, SRL and friends
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB, SRA

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                                      // Register format
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                                      // Immediate and load format
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;                                      // Store format
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;                                      // Upper immediate and jump format
    } instr_u;

endpackage
